/* include/mmu_macros.svh */
`ifndef MMU_MACROS_SVH
`define MMU_MACROS_SVH

// translation cache size, must be a power of two
`define MMU_TLB_ENTRIES 8

// bit positions inside the PTE flags byte
`define MMU_PTE_V 0
`define MMU_PTE_R 1
`define MMU_PTE_W 2
`define MMU_PTE_X 3

// memory bus command codes
`define MMU_BUS_CMD_READ 3'd1

// memory bus response codes, anything else is a bus error
`define MMU_BUS_RESP_OK 3'd0

`endif

/* logic/mmu_pkg.sv */
`default_nettype none

package mmu_pkg;

    // Sv32 page table entry as it sits in memory
    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0]  ppn0;
        logic [1:0]  rsw;
        logic [7:0]  flags;
    } pte_t;

    typedef enum logic [1:0] {
        walk_ok,
        walk_pagefault,
        walk_accessfault
    } walk_result_t;

    // one line of the direct-mapped translation cache
    typedef struct packed {
        logic        valid;
        logic [19:0] tag;
        logic [21:0] ppn;
        logic [7:0]  access_bits;
    } tlb_entry_t;

endpackage

`default_nettype wire

/* logic/mmu_if.sv */
`timescale 1ns/1ps
`default_nettype none

// walk requests from the translation cache to the walker
interface walk_if;
    logic                 start;
    logic [19:0]          vpn;
    logic [21:0]          root_ppn;
    logic                 busy;
    logic                 done;
    mmu_pkg::walk_result_t result;
    logic [21:0]          ppn;
    logic [7:0]           access_bits;

    modport requester (
        output start, vpn, root_ppn,
        input  busy, done, result, ppn, access_bits
    );

    modport walker (
        input  start, vpn, root_ppn,
        output busy, done, result, ppn, access_bits
    );
endinterface

// page table reads from the walker to the bus port
interface pt_read_if;
    logic          read;
    logic [33:0]   address;
    logic          done;
    logic [2:0]    response;
    mmu_pkg::pte_t rdata;

    modport master (
        output read, address,
        input  done, response, rdata
    );

    modport port (
        input  read, address,
        output done, response, rdata
    );
endinterface

`default_nettype wire

/* logic/mmu_tlb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_macros.svh"

module mmu_tlb (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        resolve_request,
    output logic        resolve_ack,
    input  logic [19:0] virtual_address,
    input  logic        satp_mode,
    input  logic [21:0] satp_ppn,
    input  logic        flush,
    output logic        resolve_done,
    output logic        resolve_pagefault,
    output logic        resolve_accessfault,
    output logic [21:0] resolve_physical_address,
    output logic [7:0]  resolve_access_bits,
    walk_if.requester   walk
);

    localparam int INDEX_W = $clog2(`MMU_TLB_ENTRIES);

    typedef enum logic {
        st_idle,
        st_walk
    } state_t;

    state_t              state;
    mmu_pkg::tlb_entry_t entries [`MMU_TLB_ENTRIES];
    mmu_pkg::tlb_entry_t lookup_entry;
    logic [INDEX_W-1:0]  lookup_index;
    logic [INDEX_W-1:0]  fill_index;
    logic [19:0]         saved_vpn;
    logic [21:0]         saved_root;
    logic                start_q;
    logic                flush_pending;
    logic                flush_now;
    logic                accept;
    logic                hit;

    assign lookup_index = virtual_address[INDEX_W-1:0];
    assign fill_index   = saved_vpn[INDEX_W-1:0];
    assign lookup_entry = entries[lookup_index];
    // a flush seen in the same cycle already counts against the lookup
    assign flush_now    = flush || flush_pending;
    assign hit          = lookup_entry.valid && lookup_entry.tag == virtual_address && !flush_now;
    assign resolve_ack  = state == st_idle && !walk.busy;
    assign accept       = resolve_request && resolve_ack;

    assign walk.start    = start_q;
    assign walk.vpn      = saved_vpn;
    assign walk.root_ppn = saved_root;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state               <= st_idle;
            start_q             <= 1'b0;
            flush_pending       <= 1'b0;
            resolve_done        <= 1'b0;
            resolve_pagefault   <= 1'b0;
            resolve_accessfault <= 1'b0;
        end else begin
            start_q             <= 1'b0;
            resolve_done        <= 1'b0;
            resolve_pagefault   <= 1'b0;
            resolve_accessfault <= 1'b0;
            case (state)
                st_idle: begin
                    flush_pending <= 1'b0;
                    if (accept) begin
                        if (!satp_mode || hit) begin
                            resolve_done <= 1'b1;
                        end else begin
                            state   <= st_walk;
                            start_q <= 1'b1;
                        end
                    end
                end
                st_walk: begin
                    // flush waits until the walk has finished
                    if (flush) begin
                        flush_pending <= 1'b1;
                    end
                    if (walk.done) begin
                        state               <= st_idle;
                        resolve_done        <= 1'b1;
                        resolve_pagefault   <= walk.result == mmu_pkg::walk_pagefault;
                        resolve_accessfault <= walk.result == mmu_pkg::walk_accessfault;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            saved_vpn  <= virtual_address;
            saved_root <= satp_ppn;
            if (!satp_mode) begin
                resolve_physical_address <= {2'b00, virtual_address};
                resolve_access_bits      <= 8'hff;
            end else begin
                resolve_physical_address <= lookup_entry.ppn;
                resolve_access_bits      <= lookup_entry.access_bits;
            end
        end else if (state == st_walk && walk.done) begin
            resolve_physical_address <= walk.ppn;
            resolve_access_bits      <= walk.access_bits;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (state == st_idle && flush_now) begin
            for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else if (state == st_walk && walk.done && walk.result == mmu_pkg::walk_ok) begin
            // only good translations are cached, faults walk again
            entries[fill_index].valid       <= 1'b1;
            entries[fill_index].tag         <= saved_vpn;
            entries[fill_index].ppn         <= walk.ppn;
            entries[fill_index].access_bits <= walk.access_bits;
        end
    end

endmodule

`default_nettype wire

/* logic/mmu_ptw.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_macros.svh"

module mmu_ptw (
    input  logic       clk,
    input  logic       rst_n,
    walk_if.walker     walk,
    pt_read_if.master  rd
);

    typedef enum logic {
        st_idle,
        st_walk
    } state_t;

    state_t                state;
    logic                  level;
    logic [21:0]           table_base;
    logic [19:0]           saved_vpn;
    logic                  read_q;
    logic [9:0]            vpn_part;
    logic                  pte_valid;
    logic                  pte_read;
    logic                  pte_write;
    logic                  pte_execute;
    logic                  bus_error;
    logic                  pte_invalid;
    logic                  pte_leaf;
    logic                  pte_misaligned;
    logic                  descend;
    mmu_pkg::walk_result_t result;

    // level 1 indexes with vpn[19:10], level 0 with vpn[9:0]
    assign vpn_part   = level ? saved_vpn[19:10] : saved_vpn[9:0];
    assign rd.read    = read_q;
    assign rd.address = {table_base, vpn_part, 2'b00};

    assign pte_valid   = rd.rdata.flags[`MMU_PTE_V];
    assign pte_read    = rd.rdata.flags[`MMU_PTE_R];
    assign pte_write   = rd.rdata.flags[`MMU_PTE_W];
    assign pte_execute = rd.rdata.flags[`MMU_PTE_X];

    assign bus_error      = rd.response != `MMU_BUS_RESP_OK;
    assign pte_invalid    = !pte_valid || (pte_write && !pte_read);
    assign pte_leaf       = pte_read || pte_execute;
    // megapage leaf must have ppn0 clear
    assign pte_misaligned = level && rd.rdata.ppn0 != 10'd0;
    assign descend        = !bus_error && !pte_invalid && !pte_leaf && level;

    always_comb begin
        if (bus_error) begin
            result = mmu_pkg::walk_accessfault;
        end else if (pte_invalid) begin
            result = mmu_pkg::walk_pagefault;
        end else if (pte_leaf) begin
            result = pte_misaligned ? mmu_pkg::walk_pagefault : mmu_pkg::walk_ok;
        end else begin
            // pointer where a leaf was expected
            result = mmu_pkg::walk_pagefault;
        end
    end

    assign walk.busy        = state == st_walk;
    assign walk.done        = state == st_walk && rd.done && !descend;
    assign walk.result      = result;
    assign walk.ppn         = level ? {rd.rdata.ppn1, saved_vpn[9:0]}
                                    : {rd.rdata.ppn1, rd.rdata.ppn0};
    assign walk.access_bits = rd.rdata.flags;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= st_idle;
            read_q <= 1'b0;
        end else begin
            read_q <= 1'b0;
            case (state)
                st_idle: begin
                    if (walk.start) begin
                        state  <= st_walk;
                        read_q <= 1'b1;
                    end
                end
                st_walk: begin
                    if (rd.done) begin
                        if (descend) begin
                            read_q <= 1'b1;
                        end else begin
                            state <= st_idle;
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && walk.start) begin
            level      <= 1'b1;
            table_base <= walk.root_ppn;
            saved_vpn  <= walk.vpn;
        end else if (state == st_walk && rd.done && descend) begin
            level      <= 1'b0;
            table_base <= {rd.rdata.ppn1, rd.rdata.ppn0};
        end
    end

endmodule

`default_nettype wire

/* logic/mmu_bus_port.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_macros.svh"

module mmu_bus_port (
    input  logic        clk,
    input  logic        rst_n,
    pt_read_if.port     rd,
    output logic        mem_transaction,
    output logic [2:0]  mem_cmd,
    output logic [33:0] mem_address,
    input  logic        mem_done,
    input  logic [2:0]  mem_response,
    input  logic [31:0] mem_rdata
);

    logic          done_q;
    logic [2:0]    response_q;
    mmu_pkg::pte_t rdata_q;
    logic          finish;

    assign finish      = mem_transaction && mem_done;
    assign mem_cmd     = `MMU_BUS_CMD_READ;
    assign rd.done     = done_q;
    assign rd.response = response_q;
    assign rd.rdata    = rdata_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_transaction <= 1'b0;
            done_q          <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (rd.read) begin
                mem_transaction <= 1'b1;
            end else if (finish) begin
                // held until the memory completes
                mem_transaction <= 1'b0;
                done_q          <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd.read) begin
            mem_address <= rd.address;
        end
        if (finish) begin
            response_q <= mem_response;
            rdata_q    <= mmu_pkg::pte_t'(mem_rdata);
        end
    end

endmodule

`default_nettype wire

/* logic/mmu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mmu_top (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        resolve_request,
    output logic        resolve_ack,
    input  logic [19:0] virtual_address,
    input  logic        satp_mode,
    input  logic [21:0] satp_ppn,
    input  logic        flush,
    output logic        resolve_done,
    output logic        resolve_pagefault,
    output logic        resolve_accessfault,
    output logic [21:0] resolve_physical_address,
    output logic [7:0]  resolve_access_bits,
    output logic        mem_transaction,
    output logic [2:0]  mem_cmd,
    output logic [33:0] mem_address,
    input  logic        mem_done,
    input  logic [2:0]  mem_response,
    input  logic [31:0] mem_rdata
);

    walk_if    walk ();
    pt_read_if rd ();

    // cache and request handling
    mmu_tlb u_tlb (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .resolve_request          (resolve_request),
        .resolve_ack              (resolve_ack),
        .virtual_address          (virtual_address),
        .satp_mode                (satp_mode),
        .satp_ppn                 (satp_ppn),
        .flush                    (flush),
        .resolve_done             (resolve_done),
        .resolve_pagefault        (resolve_pagefault),
        .resolve_accessfault      (resolve_accessfault),
        .resolve_physical_address (resolve_physical_address),
        .resolve_access_bits      (resolve_access_bits),
        .walk                     (walk.requester)
    );

    mmu_ptw u_ptw (
        .clk   (clk),
        .rst_n (rst_n),
        .walk  (walk.walker),
        .rd    (rd.master)
    );

    mmu_bus_port u_bus_port (
        .clk             (clk),
        .rst_n           (rst_n),
        .rd              (rd.port),
        .mem_transaction (mem_transaction),
        .mem_cmd         (mem_cmd),
        .mem_address     (mem_address),
        .mem_done        (mem_done),
        .mem_response    (mem_response),
        .mem_rdata       (mem_rdata)
    );

endmodule

`default_nettype wire

/* tb/mmu_props.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_macros.svh"

module mmu_props (
    input logic        clk,
    input logic        rst_n,
    input logic        resolve_request,
    input logic        resolve_ack,
    input logic        resolve_done,
    input logic        resolve_pagefault,
    input logic        resolve_accessfault,
    input logic [21:0] resolve_physical_address,
    input logic [7:0]  resolve_access_bits,
    input logic        mem_transaction,
    input logic [2:0]  mem_cmd,
    input logic [33:0] mem_address,
    input logic        mem_done
);

    int   fail_count = 0;
    logic pending;
    logic first_read;
    logic accept;

    assign accept = resolve_request && resolve_ack;

    // pending spans acceptance to answer
    // first_read marks the level-1 read
    always @(posedge clk) begin
        if (!rst_n) begin
            pending    <= 1'b0;
            first_read <= 1'b0;
        end else begin
            if (accept) begin
                pending    <= 1'b1;
                first_read <= 1'b1;
            end else begin
                if (resolve_done) begin
                    pending <= 1'b0;
                end
                if (mem_transaction) begin
                    first_read <= 1'b0;
                end
            end
        end
    end

    pagefault_value: assert property (@(posedge clk) disable iff (!rst_n)
        resolve_done |-> resolve_pagefault == mmu_tb.exp_pagefault)
        else begin
            fail_count++;
            $error("[ERROR] %0t resolve_pagefault expected %0b actual %0b",
                $time, $sampled(mmu_tb.exp_pagefault), $sampled(resolve_pagefault));
        end

    accessfault_value: assert property (@(posedge clk) disable iff (!rst_n)
        resolve_done |-> resolve_accessfault == mmu_tb.exp_accessfault)
        else begin
            fail_count++;
            $error("[ERROR] %0t resolve_accessfault expected %0b actual %0b",
                $time, $sampled(mmu_tb.exp_accessfault), $sampled(resolve_accessfault));
        end

    ppn_value: assert property (@(posedge clk) disable iff (!rst_n)
        resolve_done && !mmu_tb.exp_pagefault && !mmu_tb.exp_accessfault
        |-> resolve_physical_address == mmu_tb.exp_ppn)
        else begin
            fail_count++;
            $error("[ERROR] %0t resolve_physical_address expected %h actual %h",
                $time, $sampled(mmu_tb.exp_ppn), $sampled(resolve_physical_address));
        end

    access_bits_value: assert property (@(posedge clk) disable iff (!rst_n)
        resolve_done && !mmu_tb.exp_pagefault && !mmu_tb.exp_accessfault
        |-> resolve_access_bits == mmu_tb.exp_bits)
        else begin
            fail_count++;
            $error("[ERROR] %0t resolve_access_bits expected %h actual %h",
                $time, $sampled(mmu_tb.exp_bits), $sampled(resolve_access_bits));
        end

    single_fault: assert property (@(posedge clk) disable iff (!rst_n)
        resolve_pagefault || resolve_accessfault
        |-> resolve_done && !(resolve_pagefault && resolve_accessfault))
        else begin
            fail_count++;
            $error("a fault was raised without resolve_done or both faults were high");
        end

    mem_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_transaction && !mem_done |=> mem_transaction && $stable(mem_address))
        else begin
            fail_count++;
            $error("mem_transaction dropped or mem_address moved before mem_done");
        end

    read_command: assert property (@(posedge clk) disable iff (!rst_n)
        mem_transaction |-> mem_cmd == `MMU_BUS_CMD_READ)
        else begin
            fail_count++;
            $error("[ERROR] %0t mem_cmd expected %h actual %h",
                $time, `MMU_BUS_CMD_READ, $sampled(mem_cmd));
        end

    ack_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        pending && !resolve_done |-> !resolve_ack)
        else begin
            fail_count++;
            $error("resolve_ack was high while a request was still being resolved");
        end

    // bare mode and cache hits answer on the next cycle but walks never do
    answer_latency: assert property (@(posedge clk) disable iff (!rst_n)
        accept |=> resolve_done == mmu_tb.exp_hit)
        else begin
            fail_count++;
            $error("[ERROR] %0t resolve_done expected %0b actual %0b",
                $time, $sampled(mmu_tb.exp_hit), $sampled(resolve_done));
        end

    no_read_on_hit: assert property (@(posedge clk) disable iff (!rst_n)
        mmu_tb.exp_hit |-> !mem_transaction)
        else begin
            fail_count++;
            $error("mem_transaction seen on a request that should not touch memory");
        end

    level1_address: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_transaction) && first_read |-> mem_address == mmu_tb.exp_l1_addr)
        else begin
            fail_count++;
            $error("[ERROR] %0t mem_address expected %h actual %h",
                $time, $sampled(mmu_tb.exp_l1_addr), $sampled(mem_address));
        end

    level0_address: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(mem_transaction) && !first_read |-> mem_address == mmu_tb.exp_l0_addr)
        else begin
            fail_count++;
            $error("[ERROR] %0t mem_address expected %h actual %h",
                $time, $sampled(mmu_tb.exp_l0_addr), $sampled(mem_address));
        end

endmodule

`default_nettype wire

/* tb/mmu_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "mmu_macros.svh"

module mmu_tb;

    localparam int          clk_period = 100;
    localparam int          num_tests  = 13;
    localparam logic [21:0] root_ppn   = 22'd4;
    // page tables placed in this physical page answer with a bus error
    localparam logic [21:0] bad_ppn    = 22'd9;
    localparam logic [7:0]  flag_v     = 8'(1 << `MMU_PTE_V);
    localparam logic [7:0]  flag_r     = 8'(1 << `MMU_PTE_R);
    localparam logic [7:0]  flag_w     = 8'(1 << `MMU_PTE_W);
    localparam logic [7:0]  flag_x     = 8'(1 << `MMU_PTE_X);
    localparam logic [19:0] vpn_walk   = {10'h003, 10'h011};
    localparam logic [19:0] vpn_mega   = {10'h07e, 10'h2f3};
    localparam logic [19:0] vpn_fault  = {10'h07f, 10'h001};
    localparam logic [19:0] vpn_slow   = {10'h2aa, 10'h155};

    logic        clk = 1'b0;
    logic        rst_n;
    logic        resolve_request;
    logic        resolve_ack;
    logic [19:0] virtual_address;
    logic        satp_mode;
    logic [21:0] satp_ppn;
    logic        flush;
    logic        resolve_done;
    logic        resolve_pagefault;
    logic        resolve_accessfault;
    logic [21:0] resolve_physical_address;
    logic [7:0]  resolve_access_bits;
    logic        mem_transaction;
    logic [2:0]  mem_cmd;
    logic [33:0] mem_address;
    logic        mem_done = 1'b0;
    logic [2:0]  mem_response = `MMU_BUS_RESP_OK;
    logic [31:0] mem_rdata = 32'h0;

    // expected answer as read by the bound property module
    logic [21:0] exp_ppn = 22'h0;
    logic [7:0]  exp_bits = 8'h0;
    logic        exp_pagefault = 1'b0;
    logic        exp_accessfault = 1'b0;
    logic        exp_hit = 1'b0;
    logic [33:0] exp_l1_addr = 34'h0;
    logic [33:0] exp_l0_addr = 34'h0;

    logic [31:0] pt_mem [16384];
    logic [31:0] rng_state = 32'h72143a90;
    logic        mem_busy = 1'b0;
    logic        slow_mem = 1'b0;
    int          wait_left = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          timeouts = 0;
    int          errors_seen = 0;

    mmu_top u_mmu_top (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .resolve_request          (resolve_request),
        .resolve_ack              (resolve_ack),
        .virtual_address          (virtual_address),
        .satp_mode                (satp_mode),
        .satp_ppn                 (satp_ppn),
        .flush                    (flush),
        .resolve_done             (resolve_done),
        .resolve_pagefault        (resolve_pagefault),
        .resolve_accessfault      (resolve_accessfault),
        .resolve_physical_address (resolve_physical_address),
        .resolve_access_bits      (resolve_access_bits),
        .mem_transaction          (mem_transaction),
        .mem_cmd                  (mem_cmd),
        .mem_address              (mem_address),
        .mem_done                 (mem_done),
        .mem_response             (mem_response),
        .mem_rdata                (mem_rdata)
    );

    bind mmu_top mmu_props u_props (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .resolve_request          (resolve_request),
        .resolve_ack              (resolve_ack),
        .resolve_done             (resolve_done),
        .resolve_pagefault        (resolve_pagefault),
        .resolve_accessfault      (resolve_accessfault),
        .resolve_physical_address (resolve_physical_address),
        .resolve_access_bits      (resolve_access_bits),
        .mem_transaction          (mem_transaction),
        .mem_cmd                  (mem_cmd),
        .mem_address              (mem_address),
        .mem_done                 (mem_done)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [33:0] pte_addr(input logic [21:0] base, input logic [9:0] part);
        return 34'(base) * 34'd4096 + 34'(part) * 34'd4;
    endfunction

    function automatic logic [31:0] make_pte(input logic [11:0] ppn1, input logic [9:0] ppn0,
                                             input logic [7:0] flags);
        return {ppn1, ppn0, 2'b00, flags};
    endfunction

    // memory answers after 0 to 3 cycles or 6 to 9 when slowed down
    always @(negedge clk) begin
        if (!rst_n) begin
            mem_done = 1'b0;
            mem_busy = 1'b0;
        end else if (mem_done) begin
            mem_done = 1'b0;
        end else if (mem_transaction) begin
            if (!mem_busy) begin
                mem_busy  = 1'b1;
                rng_state = xorshift(rng_state);
                wait_left = int'(rng_state[1:0]) + (slow_mem ? 6 : 0);
            end
            if (wait_left == 0) begin
                mem_busy     = 1'b0;
                mem_done     = 1'b1;
                mem_response = (mem_address[33:12] == bad_ppn) ? 3'd2 : `MMU_BUS_RESP_OK;
                mem_rdata    = pt_mem[mem_address[15:2]];
            end else begin
                wait_left--;
            end
        end
    end

    // V is clear in every word so untouched entries are invalid PTEs
    task automatic clear_tables;
        for (int i = 0; i < 16384; i++) begin
            pt_mem[i] = {i[13:0], i[13:0], 4'b0000};
        end
    endtask

    task automatic write_pte(input logic [21:0] base, input logic [9:0] part,
                             input logic [31:0] pte);
        logic [33:0] addr;
        addr = pte_addr(base, part);
        pt_mem[addr[15:2]] = pte;
    endtask

    task automatic expect_result(input logic [21:0] ppn, input logic [7:0] bits,
                                 input logic pf, input logic af, input logic hit);
        exp_ppn         = ppn;
        exp_bits        = bits;
        exp_pagefault   = pf;
        exp_accessfault = af;
        exp_hit         = hit;
    endtask

    task automatic expect_walk(input logic [21:0] root, input logic [19:0] vpn,
                               input logic [21:0] l0_base);
        satp_ppn    = root;
        exp_l1_addr = pte_addr(root, vpn[19:10]);
        exp_l0_addr = pte_addr(l0_base, vpn[9:0]);
    endtask

    task automatic wait_done;
        int cycles;
        cycles = 0;
        while (!resolve_done && cycles < 64) begin
            @(negedge clk);
            cycles++;
        end
        if (!resolve_done) begin
            $display("resolve_done did not arrive within 64 cycles at %0t", $time);
            timeouts++;
        end
    endtask

    task automatic resolve(input logic [19:0] vpn);
        @(negedge clk);
        resolve_request = 1'b1;
        virtual_address = vpn;
        while (!resolve_ack) begin
            @(negedge clk);
        end
        @(negedge clk);
        resolve_request = 1'b0;
        wait_done();
    endtask

    // the request stays up through the walk and is taken again once ack returns
    task automatic hold_request(input logic [19:0] vpn);
        @(negedge clk);
        resolve_request = 1'b1;
        virtual_address = vpn;
        wait_done();
        exp_hit = 1'b1;
        @(negedge clk);
        resolve_request = 1'b0;
        wait_done();
    endtask

    task automatic finish_test(input string name);
        int errors_now;
        repeat (2) @(negedge clk);
        errors_now = u_mmu_top.u_props.fail_count + timeouts;
        tests_run++;
        if (errors_now == errors_seen) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAILED", tests_run, name);
        end
        errors_seen = errors_now;
    endtask

    initial begin
        rst_n           = 1'b0;
        resolve_request = 1'b0;
        virtual_address = 20'h0;
        satp_mode       = 1'b0;
        satp_ppn        = 22'h0;
        flush           = 1'b0;
        clear_tables();
        repeat (8) @(negedge clk);
        rst_n = 1'b1;

        expect_result({2'b00, 20'habcde}, 8'hff, 1'b0, 1'b0, 1'b1);
        resolve(20'habcde);
        finish_test("bare mode");

        satp_mode = 1'b1;
        write_pte(root_ppn, vpn_walk[19:10], make_pte(12'h000, 10'h005, flag_v));
        write_pte(22'd5, vpn_walk[9:0],
                  make_pte(12'h123, 10'h2ab, 8'hc0 | flag_v | flag_r | flag_w | flag_x));
        expect_walk(root_ppn, vpn_walk, 22'd5);
        expect_result({12'h123, 10'h2ab}, 8'hcf, 1'b0, 1'b0, 1'b0);
        resolve(vpn_walk);
        finish_test("two-level walk");

        exp_hit = 1'b1;
        resolve(vpn_walk);
        finish_test("cache hit");

        @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        // a changed leaf shows the answer came from memory
        write_pte(22'd5, vpn_walk[9:0], make_pte(12'h321, 10'h155, 8'hc0 | flag_v | flag_r));
        expect_result({12'h321, 10'h155}, 8'hc3, 1'b0, 1'b0, 1'b0);
        resolve(vpn_walk);
        finish_test("walk after flush");

        clear_tables();
        write_pte(root_ppn, vpn_mega[19:10],
                  make_pte(12'h0a5, 10'h000, 8'h40 | flag_v | flag_r | flag_x));
        expect_walk(root_ppn, vpn_mega, 22'd0);
        expect_result({12'h0a5, vpn_mega[9:0]}, 8'h4b, 1'b0, 1'b0, 1'b0);
        resolve(vpn_mega);
        finish_test("megapage");

        write_pte(root_ppn, vpn_fault[19:10],
                  make_pte(12'h0a5, 10'h004, 8'h40 | flag_v | flag_r | flag_x));
        expect_walk(root_ppn, vpn_fault, 22'd0);
        expect_result(22'h0, 8'h0, 1'b1, 1'b0, 1'b0);
        resolve(vpn_fault);
        finish_test("misaligned megapage");

        clear_tables();
        resolve(vpn_fault);
        finish_test("invalid pte");

        write_pte(root_ppn, vpn_fault[19:10], make_pte(12'h000, 10'h006, flag_v));
        write_pte(22'd6, vpn_fault[9:0], make_pte(12'h0f0, 10'h00f, flag_v | flag_w));
        expect_walk(root_ppn, vpn_fault, 22'd6);
        resolve(vpn_fault);
        finish_test("write without read");

        write_pte(22'd6, vpn_fault[9:0], make_pte(12'h000, 10'h007, flag_v));
        resolve(vpn_fault);
        finish_test("pointer at level 0");

        resolve(vpn_fault);
        finish_test("fault walked again");

        expect_walk(bad_ppn, vpn_fault, 22'd0);
        expect_result(22'h0, 8'h0, 1'b0, 1'b1, 1'b0);
        resolve(vpn_fault);
        finish_test("bus error level 1");

        clear_tables();
        write_pte(root_ppn, vpn_fault[19:10], make_pte(12'h000, bad_ppn[9:0], flag_v));
        expect_walk(root_ppn, vpn_fault, bad_ppn);
        resolve(vpn_fault);
        finish_test("bus error level 0");

        slow_mem = 1'b1;
        write_pte(root_ppn, vpn_slow[19:10], make_pte(12'h000, 10'h005, flag_v));
        write_pte(22'd5, vpn_slow[9:0],
                  make_pte(12'hfed, 10'h0c3, 8'hd0 | flag_v | flag_r | flag_x));
        expect_walk(root_ppn, vpn_slow, 22'd5);
        expect_result({12'hfed, 10'h0c3}, 8'hdb, 1'b0, 1'b0, 1'b0);
        hold_request(vpn_slow);
        slow_mem = 1'b0;
        finish_test("back-pressure");

        $display("tests run %0d, failed %0d, assertion errors %0d",
            tests_run, tests_failed, u_mmu_top.u_props.fail_count);
        if (tests_failed == 0 && errors_seen == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        #((num_tests * 64 + 8) * clk_period);
        $display("watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+include
logic/mmu_pkg.sv
logic/mmu_if.sv
logic/mmu_tlb.sv
logic/mmu_ptw.sv
logic/mmu_bus_port.sv
logic/mmu_top.sv
tb/mmu_props.sv
tb/mmu_tb.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module mmu_tb \
    -f compile.f -o mmu_sim || exit 1
out="$(./obj_dir/mmu_sim +verilator+error+limit+1000)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "^All tests passed$" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
